//--- src/dmx_cfg.svh
// Build-time settings of the DMX512 transmitter.
// Included by the RTL blocks that need rates, frame sizes or the CSR block address.

`ifndef DMX_CFG_SVH
`define DMX_CFG_SVH

// sys_clk rate in Hz, kept low so that simulation runs fast.
`define DMX_CLK_FREQ 2000000

// DMX512 line rate in bit/s.
`define DMX_BAUD 250000

// slots per frame and break length in bit times.
`define DMX_SLOTS 512
`define DMX_BREAK_BITS 26

// value of csr address bits 13:10 that selects this peripheral.
`define DMX_CSR_BLOCK 4'h2

`endif

//--- src/dmx_csr_pkg.sv
// Types of the CSR bus as seen by the DMX512 transmitter.
// Referenced by scoped name from the top level and the CSR decoder.

package dmx_csr_pkg;

	// ========================================================================
	// bus request, driven by the bus master every cycle
	// ========================================================================

	// a:  word address, bits 13:10 pick the peripheral.
	// we: write strobe for the current cycle.
	// di: write data.
	typedef struct packed {
		logic [13:0] a;
		logic        we;
		logic [31:0] di;
	} csr_req_t;

	// ========================================================================
	// read data, valid one cycle after the address
	// ========================================================================

	typedef logic [31:0] csr_word_t;

endpackage

//--- src/dmx_line_pkg.sv
// Types for the channel store and the DMX512 line side.
// Shared by the CSR decoder, the channel RAM and the frame generator.

package dmx_line_pkg;

	// channel index and channel level.
	typedef logic [8:0] chan_addr_t;
	typedef logic [7:0] chan_level_t;

	// write port of the channel RAM, CSR side.
	typedef struct packed {
		chan_addr_t  addr;
		chan_level_t level;
		logic        we;
	} chan_wr_t;

	// what the frame generator puts on the line next.
	// codes 0 to 7 pick one bit of the current slot level.
	typedef enum logic [3:0] {
		SEL_B0 = 4'd0, SEL_B1 = 4'd1, SEL_B2 = 4'd2, SEL_B3 = 4'd3,
		SEL_B4 = 4'd4, SEL_B5 = 4'd5, SEL_B6 = 4'd6, SEL_B7 = 4'd7,
		SEL_HI = 4'd8,
		SEL_LO = 4'd9
	} line_sel_t;

endpackage

//--- src/dmx_chan_ram.sv
// Dual-port channel level store, 512 x 8.
// Port A is written and read by the CSR decoder, port B is read by the frame generator.

`timescale 1ns/1ps

module dmx_chan_ram (
	input  logic                     sys_clk,
	input  dmx_line_pkg::chan_wr_t   chan_wr,
	input  dmx_line_pkg::chan_addr_t chan_rd_addr,
	output dmx_line_pkg::chan_level_t chan_rd_level,
	input  dmx_line_pkg::chan_addr_t slot_addr,
	output dmx_line_pkg::chan_level_t slot_level
);

	localparam int unsigned DEPTH = 2 ** $bits(dmx_line_pkg::chan_addr_t);

	dmx_line_pkg::chan_level_t mem [DEPTH];

	// port A, write plus registered read.
	// a read of the address being written returns the old level.
	always_ff @(posedge sys_clk) begin
		if (chan_wr.we) begin
			mem[chan_wr.addr] <= chan_wr.level;
		end
		chan_rd_level <= mem[chan_rd_addr];
	end

	// port B, registered read for the transmitter.
	always_ff @(posedge sys_clk) begin
		slot_level <= mem[slot_addr];
	end

endmodule

//--- src/dmx_csr.sv
// CSR decoder of the DMX512 transmitter.
// Maps the channel RAM at address bit 9 low and the control register at bit 9 high,
// and returns read data one cycle after the address.

`timescale 1ns/1ps

`include "dmx_cfg.svh"

module dmx_csr (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  dmx_csr_pkg::csr_req_t     csr,
	output dmx_csr_pkg::csr_word_t    csr_do,
	output dmx_line_pkg::chan_wr_t    chan_wr,
	output dmx_line_pkg::chan_addr_t  chan_rd_addr,
	input  dmx_line_pkg::chan_level_t chan_rd_level,
	output logic                      thru_en
);

	// read state of the previous cycle.
	typedef struct packed {
		logic chan;
		logic ctrl;
		logic thru;
	} rd_state_t;

	logic      blk_hit;
	rd_state_t rd_q;

	assign blk_hit = (csr.a[13:10] == 4'(`DMX_CSR_BLOCK));

	// channel space.
	assign chan_wr.addr  = csr.a[8:0];
	assign chan_wr.level = csr.di[7:0];
	assign chan_wr.we    = blk_hit & ~csr.a[9] & csr.we;
	assign chan_rd_addr  = csr.a[8:0];

	// control register, bit 0 is the thru enable.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			thru_en <= 1'b0;
		end else if (blk_hit && csr.a[9] && csr.we) begin
			thru_en <= csr.di[0];
		end
	end

	// remember which space was addressed, the RAM delivers its level in step.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rd_q <= '0;
		end else begin
			rd_q.chan <= blk_hit & ~csr.a[9];
			rd_q.ctrl <= blk_hit & csr.a[9];
			rd_q.thru <= thru_en;
		end
	end

	always_comb begin
		if (rd_q.chan) begin
			csr_do = dmx_csr_pkg::csr_word_t'(chan_rd_level);
		end else if (rd_q.ctrl) begin
			csr_do = dmx_csr_pkg::csr_word_t'(rd_q.thru);
		end else begin
			csr_do = '0;
		end
	end

endmodule

//--- src/dmx_frame_gen.sv
// DMX512 frame generator.
// Sends break, mark-after-break, a zero start code and all slots from the channel RAM,
// frame after frame, on line_bit.

`timescale 1ns/1ps

`include "dmx_cfg.svh"

module dmx_frame_gen (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	output dmx_line_pkg::chan_addr_t  slot_addr,
	input  dmx_line_pkg::chan_level_t slot_level,
	output logic                      line_bit
);

	localparam int unsigned BIT_DIV = `DMX_CLK_FREQ / `DMX_BAUD;
	localparam int unsigned DIV_W   = (BIT_DIV > 1) ? $clog2(BIT_DIV) : 1;
	localparam int unsigned BRK_W   = $clog2(`DMX_BREAK_BITS);

	localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(BIT_DIV - 1);
	localparam logic [BRK_W-1:0] BRK_LAST = BRK_W'(`DMX_BREAK_BITS - 1);
	localparam dmx_line_pkg::chan_addr_t SLOT_LAST =
		dmx_line_pkg::chan_addr_t'(`DMX_SLOTS - 1);

	typedef enum logic [3:0] {
		ST_MTBP,
		ST_BREAK,
		ST_MAB1,
		ST_MAB2,
		ST_SC_START,
		ST_SC_DATA,
		ST_SC_STOP1,
		ST_SC_STOP2,
		ST_START,
		ST_DATA,
		ST_STOP1,
		ST_STOP2
	} state_t;

	state_t                    state;
	state_t                    state_nxt;
	logic [DIV_W-1:0]          div_cnt;
	logic                      tick;
	logic [BRK_W-1:0]          brk_cnt;
	logic [2:0]                bit_idx;
	dmx_line_pkg::chan_addr_t  slot_cnt;
	logic                      slot_last;
	dmx_line_pkg::line_sel_t   sel;

	// ========================================================================
	// bit-rate tick, one pulse per bit time
	// ========================================================================

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_cnt <= DIV_LOAD;
			tick    <= 1'b0;
		end else if (div_cnt == '0) begin
			div_cnt <= DIV_LOAD;
			tick    <= 1'b1;
		end else begin
			div_cnt <= div_cnt - 1'b1;
			tick    <= 1'b0;
		end
	end

	// ========================================================================
	// counters, all stepped on ticks
	// ========================================================================

	// break length, held at the last count until the FSM leaves the break.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			brk_cnt <= '0;
		end else if (tick) begin
			if (state != ST_BREAK) begin
				brk_cnt <= '0;
			end else if (brk_cnt != BRK_LAST) begin
				brk_cnt <= brk_cnt + 1'b1;
			end
		end
	end

	// data bit position, shared by the start code and the slots.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bit_idx <= '0;
		end else if (tick) begin
			if (state == ST_SC_DATA || state == ST_DATA) begin
				bit_idx <= bit_idx + 1'b1;
			end else begin
				bit_idx <= '0;
			end
		end
	end

	// slot index, moves on in the first stop bit so the RAM read settles early.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			slot_cnt  <= '0;
			slot_last <= 1'b0;
		end else if (tick) begin
			if (state == ST_MTBP) begin
				slot_cnt  <= '0;
				slot_last <= 1'b0;
			end else if (state == ST_STOP1) begin
				slot_cnt  <= slot_cnt + 1'b1;
				slot_last <= (slot_cnt == SLOT_LAST);
			end
		end
	end

	assign slot_addr = slot_cnt;

	// ========================================================================
	// frame FSM
	// ========================================================================

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= ST_MTBP;
		end else if (tick) begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		sel       = dmx_line_pkg::SEL_HI;
		case (state)
			ST_MTBP: state_nxt = ST_BREAK;
			ST_BREAK: begin
				sel = dmx_line_pkg::SEL_LO;
				if (brk_cnt == BRK_LAST) begin
					state_nxt = ST_MAB1;
				end
			end
			ST_MAB1: state_nxt = ST_MAB2;
			ST_MAB2: state_nxt = ST_SC_START;
			ST_SC_START: begin
				sel       = dmx_line_pkg::SEL_LO;
				state_nxt = ST_SC_DATA;
			end
			// start code is all zero.
			ST_SC_DATA: begin
				sel = dmx_line_pkg::SEL_LO;
				if (bit_idx == 3'd7) begin
					state_nxt = ST_SC_STOP1;
				end
			end
			ST_SC_STOP1: state_nxt = ST_SC_STOP2;
			ST_SC_STOP2: state_nxt = ST_START;
			ST_START: begin
				sel       = dmx_line_pkg::SEL_LO;
				state_nxt = ST_DATA;
			end
			// level bits, LSB first.
			ST_DATA: begin
				sel = dmx_line_pkg::line_sel_t'({1'b0, bit_idx});
				if (bit_idx == 3'd7) begin
					state_nxt = ST_STOP1;
				end
			end
			ST_STOP1: state_nxt = ST_STOP2;
			ST_STOP2: state_nxt = slot_last ? ST_MTBP : ST_START;
			default: state_nxt = ST_MTBP;
		endcase
	end

	// registered line driver.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			line_bit <= 1'b1;
		end else begin
			case (sel)
				dmx_line_pkg::SEL_HI: line_bit <= 1'b1;
				dmx_line_pkg::SEL_LO: line_bit <= 1'b0;
				default: line_bit <= slot_level[sel[2:0]];
			endcase
		end
	end

endmodule

//--- src/dmx_tx.sv
// Top level of the DMX512 transmitter peripheral.
// Channel levels are written over the CSR bus and sent as continuous DMX512 frames on tx.
// With the thru bit set, the external DMX input is passed to tx instead.

`timescale 1ns/1ps

module dmx_tx (
	input  logic                   sys_clk,
	input  logic                   sys_rst,
	input  dmx_csr_pkg::csr_req_t  csr,
	output dmx_csr_pkg::csr_word_t csr_do,
	input  logic                   thru,
	output logic                   tx
);

	dmx_line_pkg::chan_wr_t    chan_wr;
	dmx_line_pkg::chan_addr_t  chan_rd_addr;
	dmx_line_pkg::chan_level_t chan_rd_level;
	dmx_line_pkg::chan_addr_t  slot_addr;
	dmx_line_pkg::chan_level_t slot_level;
	logic                      thru_en;
	logic                      line_bit;

	dmx_csr i_csr (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.csr           (csr),
		.csr_do        (csr_do),
		.chan_wr       (chan_wr),
		.chan_rd_addr  (chan_rd_addr),
		.chan_rd_level (chan_rd_level),
		.thru_en       (thru_en)
	);

	dmx_chan_ram i_chan_ram (
		.sys_clk       (sys_clk),
		.chan_wr       (chan_wr),
		.chan_rd_addr  (chan_rd_addr),
		.chan_rd_level (chan_rd_level),
		.slot_addr     (slot_addr),
		.slot_level    (slot_level)
	);

	dmx_frame_gen i_frame_gen (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.slot_addr  (slot_addr),
		.slot_level (slot_level),
		.line_bit   (line_bit)
	);

	// thru path is combinational.
	assign tx = thru_en ? thru : line_bit;

endmodule

//--- sim/dmx_tx_tb.sv
// Testbench for the DMX512 transmitter.
// Applies the commands of sim/dmx_testdata.txt over the CSR bus, decodes the frames
// on tx with a software UART and checks the thru path with random input.

`timescale 1ns/1ps

`include "dmx_cfg.svh"

module dmx_tx_tb;

	localparam int BIT_CLKS     = `DMX_CLK_FREQ / `DMX_BAUD;
	localparam int BREAK_MIN    = 22 * BIT_CLKS;
	localparam int FRAME_CLKS   = (1 + `DMX_BREAK_BITS + 2 + 11 * (`DMX_SLOTS + 1)) * BIT_CLKS;
	localparam int THRU_SAMPLES = 256;

	localparam logic [3:0]  BLOCK     = 4'(`DMX_CSR_BLOCK);
	localparam logic [13:0] CTRL_ADDR = {BLOCK, 1'b1, 9'd0};

	logic                   sys_clk;
	logic                   sys_rst;
	dmx_csr_pkg::csr_req_t  csr;
	dmx_csr_pkg::csr_word_t csr_do;
	logic                   thru;
	logic                   tx;

	// expected slot levels, filled from the f lines.
	logic [7:0] exp_level [`DMX_SLOTS];
	logic       exp_valid [`DMX_SLOTS];

	int     value_errs;
	int     other_errs;
	integer seed;

	dmx_tx i_dut (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr     (csr),
		.csr_do  (csr_do),
		.thru    (thru),
		.tx      (tx)
	);

	always #5 sys_clk = ~sys_clk;

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] want);
		value_errs++;
		$display("[FAIL] %s: got %h expected %h", what, got, want);
	endtask

	task automatic report_problem(input string what);
		other_errs++;
		$display("error: %s", what);
	endtask

	// ========================================================================
	// CSR bus access
	// ========================================================================

	task automatic csr_write(input logic [13:0] a, input logic [31:0] d);
		@(negedge sys_clk);
		csr.a  = a;
		csr.we = 1'b1;
		csr.di = d;
		@(negedge sys_clk);
		csr = '0;
	endtask

	// the bus goes idle before sampling, so the data must come from the registered read.
	task automatic read_check(input logic [13:0] a, input logic [31:0] want);
		@(negedge sys_clk);
		csr.a  = a;
		csr.we = 1'b0;
		csr.di = '0;
		@(negedge sys_clk);
		csr = '0;
		#1;
		assert (csr_do == want)
		else report_mismatch($sformatf("csr_do at %h", a), csr_do, want);
	endtask

	task automatic apply_testdata();
		int          fd;
		int          code;
		int          c;
		logic [7:0]  cmd;
		logic [31:0] addr;
		logic [31:0] value;
		logic        done;
		fd = $fopen("sim/dmx_testdata.txt", "r");
		assert (fd != 0) else report_problem("cannot open sim/dmx_testdata.txt");
		if (fd == 0) return;
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				done = 1'b1;
			end else if (cmd == "#") begin
				c = $fgetc(fd);
				while (c != 10 && c != -1) begin
					c = $fgetc(fd);
				end
			end else if (cmd == "t") begin
				code = $fscanf(fd, "%h", value);
				assert (code == 1) else report_problem("malformed t line in test data");
				csr_write(CTRL_ADDR, value);
			end else begin
				code = $fscanf(fd, "%h %h", addr, value);
				assert (code == 2) else report_problem("malformed line in test data");
				case (cmd)
					"w": csr_write({BLOCK, 1'b0, addr[8:0]}, value);
					"r": read_check(addr[13:0], value);
					"x": csr_write(addr[13:0], value);
					"f": begin
						exp_level[addr[8:0]] = value[7:0];
						exp_valid[addr[8:0]] = 1'b1;
					end
					default: report_problem($sformatf("unknown command %s in test data", cmd));
				endcase
			end
		end
		$fclose(fd);
	endtask

	// ========================================================================
	// software UART on tx, sampled on the falling clock edge
	// ========================================================================

	task automatic wait_for_low(input int limit, output int waited, output logic seen);
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < limit) begin
			@(negedge sys_clk);
			waited++;
			seen = (tx == 1'b0);
		end
	endtask

	// called on the first low sample of a start bit, samples each bit in its middle.
	task automatic receive_byte(input string label, output logic [7:0] data);
		int b;
		repeat (BIT_CLKS / 2 - 1) @(negedge sys_clk);
		assert (tx == 1'b0) else report_mismatch({"tx start bit of ", label}, 32'(tx), 32'h0);
		for (b = 0; b < 8; b++) begin
			repeat (BIT_CLKS) @(negedge sys_clk);
			data[b] = tx;
		end
		repeat (BIT_CLKS) @(negedge sys_clk);
		assert (tx == 1'b1) else report_mismatch({"tx stop bit 1 of ", label}, 32'(tx), 32'h1);
		repeat (BIT_CLKS) @(negedge sys_clk);
		assert (tx == 1'b1) else report_mismatch({"tx stop bit 2 of ", label}, 32'(tx), 32'h1);
	endtask

	task automatic check_frame();
		int         n;
		int         low_run;
		int         i;
		logic       found;
		logic       seen;
		logic [7:0] data;
		found   = 1'b0;
		low_run = 0;
		n       = 0;
		// a break is a long low run that ends in a high level.
		while (!found && n < 2 * FRAME_CLKS) begin
			@(negedge sys_clk);
			n++;
			if (tx == 1'b0) begin
				low_run++;
			end else if (low_run >= BREAK_MIN) begin
				found = 1'b1;
			end else begin
				low_run = 0;
			end
		end
		assert (found) else report_problem("no break found on tx");
		if (!found) return;
		wait_for_low(4 * BIT_CLKS, n, seen);
		assert (seen) else report_problem("tx stayed high after the break");
		if (!seen) return;
		assert (n >= 2 * BIT_CLKS)
		else report_problem($sformatf("mark-after-break of %0d cycles is too short", n));
		receive_byte("start code", data);
		assert (data == 8'h00) else report_mismatch("tx start code", 32'(data), 32'h0);
		for (i = 0; i < `DMX_SLOTS; i++) begin
			wait_for_low(2 * BIT_CLKS, n, seen);
			assert (seen) else report_problem($sformatf("no start bit for slot %0d", i));
			if (!seen) return;
			receive_byte($sformatf("slot %0d", i), data);
			if (exp_valid[i]) begin
				assert (data == exp_level[i])
				else report_mismatch($sformatf("tx slot %0d", i), 32'(data), 32'(exp_level[i]));
			end
		end
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		int     i;
		integer rnd;
		seed       = 32'h7c28d3fc;
		sys_clk    = 1'b0;
		sys_rst    = 1'b1;
		csr        = '0;
		thru       = 1'b0;
		value_errs = 0;
		other_errs = 0;
		for (i = 0; i < `DMX_SLOTS; i++) begin
			exp_level[i] = 8'h00;
			exp_valid[i] = 1'b0;
		end

		repeat (10) @(negedge sys_clk);
		sys_rst = 1'b0;
		#1;
		assert (tx == 1'b1) else report_mismatch("tx after reset", 32'(tx), 32'h1);
		assert (csr_do == '0) else report_mismatch("csr_do after reset", csr_do, 32'h0);

		// the channel RAM has no reset.
		for (i = 0; i < `DMX_SLOTS; i++) begin
			csr_write({BLOCK, 1'b0, 9'(i)}, 32'h0);
		end

		apply_testdata();
		check_frame();

		// thru mode, tx follows the random input.
		csr_write(CTRL_ADDR, 32'h1);
		rnd  = $random(seed);
		thru = rnd[0];
		for (i = 0; i < THRU_SAMPLES; i++) begin
			@(negedge sys_clk);
			assert (tx == thru) else report_mismatch("tx in thru mode", 32'(tx), 32'(thru));
			rnd  = $random(seed);
			thru = rnd[0];
		end
		csr_write(CTRL_ADDR, 32'h0);
		thru = 1'b0;
		check_frame();

		$display("value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+src
src/dmx_csr_pkg.sv
src/dmx_line_pkg.sv
src/dmx_chan_ram.sv
src/dmx_csr.sv
src/dmx_frame_gen.sv
src/dmx_tx.sv
sim/dmx_tx_tb.sv

//--- run.sh
#!/bin/sh
# Builds the DMX512 transmitter testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module dmx_tx_tb -Mdir obj_dir

./obj_dir/Vdmx_tx_tb | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- sim/dmx_testdata.txt
# columns: command, address or slot (hex), value (hex)
# w chan level | r csr_addr expected | t ctrl | x csr_addr data | f slot level
w 000 11
w 001 a5
w 002 ffffff3c
w 07f 80
w 100 01
w 1fe 7e
w 1ff ff
r 0800 00000011
r 0801 000000a5
r 0802 0000003c
r 087f 00000080
r 09ff 000000ff
r 0803 00000000
t 1
r 0a00 00000001
t 0
r 0a00 00000000
x 0c01 0000005a
x 0001 0000005a
r 0801 000000a5
r 0c01 00000000
x 0e00 00000001
r 0a00 00000000
f 000 11
f 001 a5
f 002 3c
f 003 00
f 07f 80
f 100 01
f 1ff ff
